// ==== design/cpuPkg.sv ====
package cpuPkg;

  //////////////////////////////////////////////////
  // Machine widths
  //////////////////////////////////////////////////
  localparam int dataWidth   = 16;  // Word size of registers, memories and instructions
  localparam int regIdxWidth = 4;   // Sixteen architectural registers

  //////////////////////////////////////////////////
  // Instruction set
  //////////////////////////////////////////////////
  // Opcode lives in instr[15:12], followed by rd, rs and rt nibbles
  typedef enum logic [3:0] {
    ADD = 4'h0,  // rd = rs + rt
    SUB = 4'h1,  // rd = rs - rt
    AND = 4'h2,  // rd = rs & rt
    XOR = 4'h3,  // rd = rs ^ rt
    LLB = 4'h4,  // rd = sign-extended low byte
    LW  = 4'h5,  // rd = mem[rs + offset]
    SW  = 4'h6,  // mem[rs + offset] = rd
    HLT = 4'h7,  // Stops fetch and raises halted at write-back
    NOP = 4'h8   // Also stands in for every undefined encoding
  } opcodeT;

  // Operand source picked by the forwarding logic in execute
  typedef enum logic [1:0] {
    fwdNone  = 2'b00,  // Value read from the register file in decode
    fwdMemWb = 2'b01,  // Value being written back this cycle
    fwdExMem = 2'b10   // Result sitting in the EX/MEM register
  } fwdSelT;

  // Instruction word loaded into pipeline registers on reset, squash and bubble
  localparam logic [dataWidth-1:0] nopInstr = {NOP, 12'h000};

endpackage

// ==== design/syncRam.sv ====
module syncRam #(
  parameter int addrWidth = 6,   // Word address bits
  parameter int dataWidth = 16   // Bits per word
) (
  input  logic                 clk,
  input  logic                 wrEn,    // Write strobe, sampled on the rising edge
  input  logic [addrWidth-1:0] wrAddr,
  input  logic [dataWidth-1:0] wrData,
  input  logic [addrWidth-1:0] rdAddr,
  output logic [dataWidth-1:0] rdData   // Available in the same cycle as rdAddr
);

  // Storage array, contents undefined until written
  logic [dataWidth-1:0] mem [1 << addrWidth];

  always_ff @(posedge clk) begin
    if (wrEn) begin
      mem[wrAddr] <= wrData;
    end
  end

  // Asynchronous read port so fetch and MEM each finish in one cycle
  assign rdData = mem[rdAddr];

endmodule

// ==== design/regFile.sv ====
module regFile (
  input  logic                           clk,
  input  logic                           arstN,
  input  logic                           wrEn,     // Write-back enable
  input  logic [cpuPkg::regIdxWidth-1:0] wrIdx,
  input  logic [cpuPkg::dataWidth-1:0]   wrData,
  input  logic [cpuPkg::regIdxWidth-1:0] rdIdxA,   // First source in decode
  output logic [cpuPkg::dataWidth-1:0]   rdDataA,
  input  logic [cpuPkg::regIdxWidth-1:0] rdIdxB,   // Second source or store data in decode
  output logic [cpuPkg::dataWidth-1:0]   rdDataB,
  input  logic [cpuPkg::regIdxWidth-1:0] dbgIdx,   // Debug peek from outside the core
  output logic [cpuPkg::dataWidth-1:0]   dbgData
);

  logic [cpuPkg::dataWidth-1:0] regs [1 << cpuPkg::regIdxWidth];
  logic                         wrLive;  // A write that actually lands this cycle

  // Register 0 is hardwired, so a write to it is dropped here
  assign wrLive = wrEn && (wrIdx != '0);

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      for (int i = 0; i < (1 << cpuPkg::regIdxWidth); i++) begin
        regs[i] <= '0;
      end
    end else if (wrLive) begin
      regs[wrIdx] <= wrData;
    end
  end

  //////////////////////////////////////////////////
  // Read ports with write-through
  //////////////////////////////////////////////////
  // Decode sees the value being written back in the same cycle
  assign rdDataA = (wrLive && wrIdx == rdIdxA) ? wrData : regs[rdIdxA];
  assign rdDataB = (wrLive && wrIdx == rdIdxB) ? wrData : regs[rdIdxB];
  assign dbgData = (wrLive && wrIdx == dbgIdx) ? wrData : regs[dbgIdx];

  // Neither decode port may ever return a nonzero value for register 0
  zeroRegReadsZero: assert property (@(posedge clk) disable iff (!arstN)
    (rdIdxA != '0 || rdDataA == '0) && (rdIdxB != '0 || rdDataB == '0));

endmodule

// ==== design/controlUnit.sv ====
module controlUnit (
  input  logic [cpuPkg::dataWidth-1:0]   instr,
  output cpuPkg::opcodeT                 opcode,    // Undefined encodings come out as NOP
  output logic [cpuPkg::regIdxWidth-1:0] rd,        // Destination, or store data for SW
  output logic [cpuPkg::regIdxWidth-1:0] rs,        // First source, zero when unused
  output logic [cpuPkg::regIdxWidth-1:0] rt,        // Second source index, zero when unused
  output logic [cpuPkg::dataWidth-1:0]   imm,       // Sign-extended immediate
  output logic                           regWrite,
  output logic                           memRead,
  output logic                           memWrite,
  output logic                           useSrcB,   // ALU operand B comes from rt, not imm
  output logic                           isHalt
);

  always_comb begin
    // Defaults describe a NOP
    opcode   = cpuPkg::opcodeT'(instr[15:12]);
    rd       = instr[11:8];
    rs       = instr[7:4];
    rt       = '0;
    imm      = '0;
    regWrite = 1'b0;
    memRead  = 1'b0;
    memWrite = 1'b0;
    useSrcB  = 1'b0;
    isHalt   = 1'b0;
    case (opcode)
      cpuPkg::ADD, cpuPkg::SUB, cpuPkg::AND, cpuPkg::XOR: begin
        rt       = instr[3:0];
        regWrite = 1'b1;
        useSrcB  = 1'b1;
      end
      cpuPkg::LLB: begin
        rs       = '0;  // Low byte overlaps rs, so no source is named
        imm      = {{(cpuPkg::dataWidth - 8){instr[7]}}, instr[7:0]};
        regWrite = 1'b1;
      end
      cpuPkg::LW: begin
        imm      = {{(cpuPkg::dataWidth - 4){instr[3]}}, instr[3:0]};
        regWrite = 1'b1;
        memRead  = 1'b1;
      end
      cpuPkg::SW: begin
        // Store data rides the second source path but never feeds the ALU
        rt       = instr[11:8];
        imm      = {{(cpuPkg::dataWidth - 4){instr[3]}}, instr[3:0]};
        memWrite = 1'b1;
      end
      cpuPkg::HLT: begin
        rs     = '0;
        isHalt = 1'b1;
      end
      default: begin
        rs     = '0;
        opcode = cpuPkg::NOP;  // Covers NOP and unused opcodes
      end
    endcase
  end

endmodule

// ==== design/alu.sv ====
module alu (
  input  cpuPkg::opcodeT               opcode,
  input  logic [cpuPkg::dataWidth-1:0] operandA,  // rs value or forwarded result
  input  logic [cpuPkg::dataWidth-1:0] operandB,  // rt value or immediate
  output logic [cpuPkg::dataWidth-1:0] result
);

  always_comb begin
    case (opcode)
      cpuPkg::ADD, cpuPkg::LW, cpuPkg::SW: begin
        result = operandA + operandB;  // Memory ops reuse the adder for base plus offset
      end
      cpuPkg::SUB: result = operandA - operandB;
      cpuPkg::AND: result = operandA & operandB;
      cpuPkg::XOR: result = operandA ^ operandB;
      cpuPkg::LLB: result = operandB;  // Immediate passes straight through
      default:     result = '0;        // NOP and HLT write nothing
    endcase
  end

endmodule

// ==== design/forwardingUnit.sv ====
module forwardingUnit (
  input  logic [cpuPkg::regIdxWidth-1:0] idExSrcReg1,    // First source of the op in execute
  input  logic [cpuPkg::regIdxWidth-1:0] idExSrcReg2,    // Second source or store data register
  input  logic [cpuPkg::regIdxWidth-1:0] exMemRd,        // Destination or store data in MEM
  input  logic [cpuPkg::regIdxWidth-1:0] memWbRd,        // Destination in write-back
  input  logic                           exMemRegWrite,
  input  logic                           memWbRegWrite,
  output cpuPkg::fwdSelT                 forwardA,
  output cpuPkg::fwdSelT                 forwardB,
  output logic                           forwardMem      // Replace store data in MEM
);

  logic exMemLive;  // EX/MEM will write a real register
  logic memWbLive;  // MEM/WB is writing a real register now

  // Register 0 is never a forwarding source
  assign exMemLive = exMemRegWrite && (exMemRd != '0);
  assign memWbLive = memWbRegWrite && (memWbRd != '0);

  //////////////////////////////////////////////////
  // EX-to-EX and MEM-to-EX
  //////////////////////////////////////////////////
  // EX/MEM is checked first because it holds the younger producer
  assign forwardA = (exMemLive && exMemRd == idExSrcReg1) ? cpuPkg::fwdExMem :
                    (memWbLive && memWbRd == idExSrcReg1) ? cpuPkg::fwdMemWb :
                    cpuPkg::fwdNone;

  assign forwardB = (exMemLive && exMemRd == idExSrcReg2) ? cpuPkg::fwdExMem :
                    (memWbLive && memWbRd == idExSrcReg2) ? cpuPkg::fwdMemWb :
                    cpuPkg::fwdNone;

  //////////////////////////////////////////////////
  // MEM-to-MEM
  //////////////////////////////////////////////////
  // Lets a store use the word loaded just ahead of it without a stall
  assign forwardMem = memWbLive && (memWbRd == exMemRd);

endmodule

// ==== design/hazardUnit.sv ====
module hazardUnit (
  input  logic                           idExMemRead,   // Execute holds a load
  input  logic [cpuPkg::regIdxWidth-1:0] idExRd,        // Register that load will fill
  input  logic [cpuPkg::regIdxWidth-1:0] ifIdRs,        // First source of the op in decode
  input  logic [cpuPkg::regIdxWidth-1:0] ifIdSrcB,      // Second source of the op in decode
  input  logic                           ifIdUsesSrcB,  // Second source feeds the ALU
  output logic                           stall
);

  logic loadLive;  // A load in execute that writes a real register

  assign loadLive = idExMemRead && (idExRd != '0);

  // Store data is not flagged through ifIdUsesSrcB, so MEM-to-MEM covers it
  // A load base or ALU operand that needs the loaded word waits one cycle
  assign stall = loadLive &&
                 ((idExRd == ifIdRs) || (ifIdUsesSrcB && idExRd == ifIdSrcB));

endmodule

// ==== design/pipeCpu.sv ====
module pipeCpu #(
  parameter int instrAddrWidth = 6,  // Instruction memory depth is 2**instrAddrWidth
  parameter int dataAddrWidth  = 6   // Data memory depth is 2**dataAddrWidth
) (
  input  logic                           clk,
  input  logic                           arstN,
  input  logic                           run,       // Fetch enable, program loads while low
  input  logic                           progWrEn,
  input  logic [instrAddrWidth-1:0]      progAddr,
  input  logic [cpuPkg::dataWidth-1:0]   progData,
  input  logic [cpuPkg::regIdxWidth-1:0] dbgAddr,
  output logic [cpuPkg::dataWidth-1:0]   dbgData,
  output logic                           halted     // Sticky until reset
);

  localparam int wordW = cpuPkg::dataWidth;
  localparam int idxW  = cpuPkg::regIdxWidth;

  // Fetch
  logic [instrAddrWidth-1:0] pc;
  logic [wordW-1:0]          fetchInstr;
  logic                      fetchEn;
  logic                      haltSeen;  // HLT has left decode, nothing more is fetched
  logic                      stall;
  // Decode
  logic [wordW-1:0]          ifIdInstr;
  cpuPkg::opcodeT            idOpcode;
  logic [idxW-1:0]           idRd, idRs, idRt;
  logic [wordW-1:0]          idImm, idRsData, idRtData;
  logic                      idRegWrite, idMemRead, idMemWrite, idUseSrcB, idIsHalt;
  // Execute
  cpuPkg::opcodeT            idExOpcode;
  logic [idxW-1:0]           idExRd, idExRs, idExRt;
  logic [wordW-1:0]          idExRsData, idExRtData, idExImm;
  logic                      idExRegWrite, idExMemRead, idExMemWrite, idExUseSrcB, idExIsHalt;
  cpuPkg::fwdSelT            forwardA, forwardB;
  logic                      forwardMem;
  logic [wordW-1:0]          srcAVal, srcBVal, aluB, aluResult;
  // Memory
  logic [wordW-1:0]          exMemResult, exMemStoreData, storeData, loadData;
  logic [idxW-1:0]           exMemRd;
  logic                      exMemRegWrite, exMemMemRead, exMemMemWrite, exMemIsHalt;
  // Write-back
  logic [wordW-1:0]          memWbResult, memWbLoadData, wbData;
  logic [idxW-1:0]           memWbRd;
  logic                      memWbRegWrite, memWbMemRead;

  //////////////////////////////////////////////////
  // Fetch
  //////////////////////////////////////////////////
  // A HLT in decode already squashes the word being fetched behind it
  assign fetchEn = run && !haltSeen && !idIsHalt;

  syncRam #(.addrWidth(instrAddrWidth), .dataWidth(wordW)) instrMem (
    .clk    (clk),
    .wrEn   (progWrEn),
    .wrAddr (progAddr),
    .wrData (progData),
    .rdAddr (pc),
    .rdData (fetchInstr)
  );

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      pc        <= '0;
      ifIdInstr <= cpuPkg::nopInstr;
      haltSeen  <= 1'b0;
      halted    <= 1'b0;
    end else begin
      if (!stall) begin  // Stall freezes PC and IF/ID together
        ifIdInstr <= fetchEn ? fetchInstr : cpuPkg::nopInstr;
        if (fetchEn) begin
          pc <= pc + 1'b1;
        end
      end
      if (idIsHalt) begin
        haltSeen <= 1'b1;
      end
      if (exMemIsHalt) begin
        halted <= 1'b1;  // Rises as HLT enters write-back
      end
    end
  end

  //////////////////////////////////////////////////
  // Decode
  //////////////////////////////////////////////////
  controlUnit decoder (
    .instr    (ifIdInstr),
    .opcode   (idOpcode),
    .rd       (idRd),
    .rs       (idRs),
    .rt       (idRt),
    .imm      (idImm),
    .regWrite (idRegWrite),
    .memRead  (idMemRead),
    .memWrite (idMemWrite),
    .useSrcB  (idUseSrcB),
    .isHalt   (idIsHalt)
  );

  regFile regBank (
    .clk     (clk),
    .arstN   (arstN),
    .wrEn    (memWbRegWrite),
    .wrIdx   (memWbRd),
    .wrData  (wbData),
    .rdIdxA  (idRs),
    .rdDataA (idRsData),
    .rdIdxB  (idRt),
    .rdDataB (idRtData),
    .dbgIdx  (dbgAddr),
    .dbgData (dbgData)
  );

  hazardUnit hazUnit (
    .idExMemRead  (idExMemRead),
    .idExRd       (idExRd),
    .ifIdRs       (idRs),
    .ifIdSrcB     (idRt),
    .ifIdUsesSrcB (idUseSrcB),
    .stall        (stall)
  );

  // ID/EX control, a stall turns the decode op into a bubble
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      idExOpcode   <= cpuPkg::NOP;
      idExRd       <= '0;
      idExRs       <= '0;
      idExRt       <= '0;
      idExRegWrite <= 1'b0;
      idExMemRead  <= 1'b0;
      idExMemWrite <= 1'b0;
      idExUseSrcB  <= 1'b0;
      idExIsHalt   <= 1'b0;
    end else begin
      idExOpcode   <= stall ? cpuPkg::NOP : idOpcode;
      idExRd       <= stall ? '0 : idRd;
      idExRs       <= stall ? '0 : idRs;
      idExRt       <= stall ? '0 : idRt;
      idExRegWrite <= idRegWrite && !stall;
      idExMemRead  <= idMemRead && !stall;
      idExMemWrite <= idMemWrite && !stall;
      idExUseSrcB  <= idUseSrcB && !stall;
      idExIsHalt   <= idIsHalt && !stall;
    end
  end

  //////////////////////////////////////////////////
  // Execute
  //////////////////////////////////////////////////
  forwardingUnit fwdUnit (
    .idExSrcReg1   (idExRs),
    .idExSrcReg2   (idExRt),
    .exMemRd       (exMemRd),
    .memWbRd       (memWbRd),
    .exMemRegWrite (exMemRegWrite),
    .memWbRegWrite (memWbRegWrite),
    .forwardA      (forwardA),
    .forwardB      (forwardB),
    .forwardMem    (forwardMem)
  );

  // Operand muxes, srcBVal also carries the store data of SW
  assign srcAVal = (forwardA == cpuPkg::fwdExMem) ? exMemResult :
                   (forwardA == cpuPkg::fwdMemWb) ? wbData : idExRsData;
  assign srcBVal = (forwardB == cpuPkg::fwdExMem) ? exMemResult :
                   (forwardB == cpuPkg::fwdMemWb) ? wbData : idExRtData;
  assign aluB    = idExUseSrcB ? srcBVal : idExImm;

  alu execAlu (
    .opcode   (idExOpcode),
    .operandA (srcAVal),
    .operandB (aluB),
    .result   (aluResult)
  );

  //////////////////////////////////////////////////
  // Memory and write-back
  //////////////////////////////////////////////////
  // A load right before a store hands its word over here
  assign storeData = forwardMem ? wbData : exMemStoreData;

  syncRam #(.addrWidth(dataAddrWidth), .dataWidth(wordW)) dataMem (
    .clk    (clk),
    .wrEn   (exMemMemWrite),
    .wrAddr (exMemResult[dataAddrWidth-1:0]),
    .wrData (storeData),
    .rdAddr (exMemResult[dataAddrWidth-1:0]),
    .rdData (loadData)
  );

  assign wbData = memWbMemRead ? memWbLoadData : memWbResult;

  // EX/MEM and MEM/WB control
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      exMemRd       <= '0;
      exMemRegWrite <= 1'b0;
      exMemMemRead  <= 1'b0;
      exMemMemWrite <= 1'b0;
      exMemIsHalt   <= 1'b0;
      memWbRd       <= '0;
      memWbRegWrite <= 1'b0;
      memWbMemRead  <= 1'b0;
    end else begin
      exMemRd       <= idExRd;
      exMemRegWrite <= idExRegWrite;
      exMemMemRead  <= idExMemRead;
      exMemMemWrite <= idExMemWrite;
      exMemIsHalt   <= idExIsHalt;
      memWbRd       <= exMemRd;
      memWbRegWrite <= exMemRegWrite;
      memWbMemRead  <= exMemMemRead;
    end
  end

  // Data payload of every stage, only meaningful under its control bits
  always_ff @(posedge clk) begin
    idExRsData     <= idRsData;
    idExRtData     <= idRtData;
    idExImm        <= idImm;
    exMemResult    <= aluResult;
    exMemStoreData <= srcBVal;
    memWbResult    <= exMemResult;
    memWbLoadData  <= loadData;
  end

  // The load-use bubble empties execute, so the same op never waits twice
  stallSingleCycle: assert property (@(posedge clk) disable iff (!arstN)
    stall |=> !stall);

  // When both older ops write source 1, the younger EX/MEM result wins
  newestProducerWins: assert property (@(posedge clk) disable iff (!arstN)
    (exMemRegWrite && exMemRd == idExRs) |-> (forwardA != cpuPkg::fwdMemWb));

endmodule

// ==== test/pipeCpuTb.sv ====
module pipeCpuTb;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int clkPeriod  = 40;
  localparam int haltLimit  = 80;    // Cycles a program may take from run to halted
  localparam int cycleLimit = 1000;  // Five tests at up to 150 cycles each, plus margin

  logic        clk;
  logic        arstN;
  logic        run;
  logic        progWrEn;
  logic [5:0]  progAddr;
  logic [15:0] progData;
  logic [3:0]  dbgAddr;
  logic [15:0] dbgData;
  logic        halted;

  logic [15:0] progWords [$];     // Program of the current test
  logic [15:0] modelRegs [16];    // Register file of the reference interpreter
  logic [15:0] modelMem  [64];    // Data memory of the reference interpreter
  logic [31:0] lcgState = 32'h18da3352;
  int          errorCount = 0;
  int          checkCount = 0;
  int          cycleCount = 0;

  pipeCpu #(.instrAddrWidth(6), .dataAddrWidth(6)) i_dut (
    .clk      (clk),
    .arstN    (arstN),
    .run      (run),
    .progWrEn (progWrEn),
    .progAddr (progAddr),
    .progData (progData),
    .dbgAddr  (dbgAddr),
    .dbgData  (dbgData),
    .halted   (halted)
  );

  initial begin
    clk = 1'b0;
    forever #(clkPeriod / 2) clk = ~clk;
  end

  //////////////////////////////////////////////////
  // Stimulus helpers
  //////////////////////////////////////////////////
  // Next pseudo-random byte, taken from the upper half of the LCG state
  function automatic logic [7:0] randByte();
    lcgState = lcgState * 32'd1664525 + 32'd1013904223;
    return lcgState[23:16];
  endfunction

  function automatic logic [15:0] rType(cpuPkg::opcodeT op, int rd, int rs, int rt);
    return {op, rd[3:0], rs[3:0], rt[3:0]};
  endfunction

  function automatic logic [15:0] llbWord(int rd, logic [7:0] imm);
    return {cpuPkg::LLB, rd[3:0], imm};
  endfunction

  function automatic logic [15:0] memWord(cpuPkg::opcodeT op, int rd, int rs, int off);
    return {op, rd[3:0], rs[3:0], off[3:0]};  // Offset is a signed nibble
  endfunction

  task automatic appendNops(int count);
    repeat (count) progWords.push_back({cpuPkg::NOP, 12'h000});
  endtask

  task automatic resetCore();
    @(posedge clk);
    #2;
    arstN    = 1'b0;  // Run and the program port go quiet while in reset
    run      = 1'b0;
    progWrEn = 1'b0;
    repeat (10) @(posedge clk);
    #2;
    arstN = 1'b1;
  endtask

  task automatic loadProgram();
    for (int i = 0; i < progWords.size(); i++) begin
      @(posedge clk);
      #2;
      progWrEn = 1'b1;
      progAddr = i[5:0];
      progData = progWords[i];
    end
    @(posedge clk);
    #2;
    progWrEn = 1'b0;
  endtask

  //////////////////////////////////////////////////
  // Reference interpreter
  //////////////////////////////////////////////////
  // Runs the program one instruction at a time, stopping at the first HLT
  task automatic runModel();
    logic [15:0] instr;
    logic [15:0] value;
    logic [15:0] addr;
    logic [3:0]  rd;
    logic [3:0]  rs;
    logic [3:0]  rt;
    bit          writes;
    bit          stopped;
    int          pcIdx;
    for (int r = 0; r < 16; r++) modelRegs[r] = '0;
    for (int a = 0; a < 64; a++) modelMem[a] = '0;
    pcIdx   = 0;
    stopped = 1'b0;
    while (!stopped && pcIdx < progWords.size()) begin
      instr  = progWords[pcIdx];
      rd     = instr[11:8];
      rs     = instr[7:4];
      rt     = instr[3:0];
      addr   = modelRegs[rs] + {{12{instr[3]}}, instr[3:0]};  // Base plus signed offset
      value  = '0;
      writes = 1'b1;
      case (instr[15:12])
        cpuPkg::ADD: value = modelRegs[rs] + modelRegs[rt];
        cpuPkg::SUB: value = modelRegs[rs] - modelRegs[rt];
        cpuPkg::AND: value = modelRegs[rs] & modelRegs[rt];
        cpuPkg::XOR: value = modelRegs[rs] ^ modelRegs[rt];
        cpuPkg::LLB: value = {{8{instr[7]}}, instr[7:0]};
        cpuPkg::LW:  value = modelMem[addr[5:0]];
        cpuPkg::SW: begin
          modelMem[addr[5:0]] = modelRegs[rd];  // Store data is named by the rd field
          writes = 1'b0;
        end
        cpuPkg::HLT: begin
          stopped = 1'b1;
          writes  = 1'b0;
        end
        default: writes = 1'b0;  // NOP and unused encodings
      endcase
      if (writes && rd != 4'd0) modelRegs[rd] = value;  // Register 0 stays zero
      pcIdx++;
    end
  endtask

  //////////////////////////////////////////////////
  // Run and check
  //////////////////////////////////////////////////
  task automatic compareRegs(string testName);
    for (int i = 0; i < 16; i++) begin
      @(posedge clk);
      #2;
      dbgAddr = i[3:0];
      #10;  // Debug read is combinational, sample well before the next edge
      checkCount++;
      if (dbgData !== modelRegs[i]) begin
        $display("FAILED at %0t: %s r%0d expected %h, got %h",
                 $time, testName, i, modelRegs[i], dbgData);
        errorCount++;
      end
    end
  endtask

  // Reset, load, run until halted, then compare every register with the model
  task automatic runProgram(string testName);
    int waited;
    resetCore();
    loadProgram();
    run    = 1'b1;
    waited = 0;
    while (!halted && waited < haltLimit) begin
      @(posedge clk);
      #2;
      waited++;
    end
    checkCount++;
    if (!halted) begin
      $display("Error in %s: halted did not rise within %0d cycles", testName, haltLimit);
      errorCount++;
    end else begin
      runModel();
      compareRegs(testName);
    end
  endtask

  //////////////////////////////////////////////////
  // Directed tests
  //////////////////////////////////////////////////
  task automatic independentAluTest();
    progWords.delete();
    progWords.push_back(llbWord(1, randByte()));
    progWords.push_back(llbWord(2, randByte()));
    progWords.push_back(llbWord(3, randByte()));
    appendNops(3);                                   // Sources settle in the register file
    progWords.push_back(rType(cpuPkg::ADD, 4, 1, 2));
    appendNops(3);
    progWords.push_back(rType(cpuPkg::SUB, 5, 1, 3));
    appendNops(3);
    progWords.push_back(rType(cpuPkg::AND, 6, 2, 3));
    appendNops(3);
    progWords.push_back(rType(cpuPkg::XOR, 7, 1, 2));
    progWords.push_back({cpuPkg::HLT, 12'h000});
    runProgram("independentAlu");
  endtask

  task automatic forwardingTest();
    progWords.delete();
    progWords.push_back(llbWord(1, randByte()));
    progWords.push_back(llbWord(2, randByte()));
    progWords.push_back(rType(cpuPkg::ADD, 3, 1, 2));  // MEM-to-EX on A, EX-to-EX on B
    progWords.push_back(rType(cpuPkg::XOR, 4, 3, 1));  // EX-to-EX on A
    progWords.push_back(rType(cpuPkg::ADD, 5, 4, 3));  // EX-to-EX on A, MEM-to-EX on B
    progWords.push_back(rType(cpuPkg::SUB, 6, 3, 5));  // EX-to-EX on B
    progWords.push_back(llbWord(7, randByte()));
    progWords.push_back(llbWord(7, randByte()));       // Younger write of r7 must win
    progWords.push_back(rType(cpuPkg::ADD, 8, 7, 7));
    progWords.push_back(llbWord(10, randByte()));
    appendNops(1);
    progWords.push_back(rType(cpuPkg::AND, 11, 2, 10)); // MEM-to-EX on B only
    progWords.push_back(rType(cpuPkg::SUB, 12, 11, 8));
    progWords.push_back({cpuPkg::HLT, 12'h000});
    runProgram("forwarding");
  endtask

  task automatic zeroRegTest();
    progWords.delete();
    progWords.push_back(llbWord(1, randByte()));
    progWords.push_back(rType(cpuPkg::ADD, 0, 1, 1));  // Result must not reach r0
    progWords.push_back(rType(cpuPkg::ADD, 2, 0, 1));  // r0 in EX/MEM is never forwarded
    progWords.push_back(llbWord(0, randByte()));
    progWords.push_back(rType(cpuPkg::XOR, 3, 0, 1));
    progWords.push_back(rType(cpuPkg::SUB, 4, 1, 0));
    appendNops(3);
    progWords.push_back(rType(cpuPkg::ADD, 5, 0, 0));
    progWords.push_back({cpuPkg::HLT, 12'h000});
    runProgram("zeroReg");
  endtask

  task automatic loadStoreTest();
    progWords.delete();
    progWords.push_back(llbWord(1, 8'h10));             // Base address 16
    progWords.push_back(llbWord(2, randByte()));
    progWords.push_back(memWord(cpuPkg::SW, 2, 1, 3));
    progWords.push_back(memWord(cpuPkg::LW, 3, 1, 3));
    progWords.push_back(rType(cpuPkg::ADD, 4, 3, 2));  // Load-use on A costs one stall
    progWords.push_back(memWord(cpuPkg::LW, 5, 1, 3));
    progWords.push_back(memWord(cpuPkg::SW, 5, 1, -2)); // MEM-to-MEM store of the load
    progWords.push_back(memWord(cpuPkg::LW, 6, 1, -2));
    progWords.push_back(llbWord(9, randByte()));
    progWords.push_back(memWord(cpuPkg::SW, 9, 1, 5));
    progWords.push_back(memWord(cpuPkg::LW, 10, 1, 5));
    progWords.push_back(rType(cpuPkg::ADD, 11, 2, 10)); // Load-use on B
    progWords.push_back({cpuPkg::HLT, 12'h000});
    runProgram("loadStore");
  endtask

  task automatic haltTest();
    progWords.delete();
    progWords.push_back(llbWord(1, randByte()));
    progWords.push_back(llbWord(2, randByte()));
    progWords.push_back(rType(cpuPkg::ADD, 3, 1, 2));
    progWords.push_back({cpuPkg::HLT, 12'h000});
    progWords.push_back(llbWord(4, randByte()));       // None of these may retire
    progWords.push_back(rType(cpuPkg::ADD, 5, 1, 2));
    progWords.push_back(llbWord(1, randByte()));
    progWords.push_back({cpuPkg::HLT, 12'h000});
    runProgram("halt");
    checkCount++;
    if (!halted) begin
      $display("Error in halt: halted dropped before the next reset");
      errorCount++;
    end
  endtask

  //////////////////////////////////////////////////
  // Main sequence and watchdog
  //////////////////////////////////////////////////
  initial begin
    arstN    = 1'b0;
    run      = 1'b0;
    progWrEn = 1'b0;
    progAddr = '0;
    progData = '0;
    dbgAddr  = '0;
    independentAluTest();
    forwardingTest();
    zeroRegTest();
    loadStoreTest();
    haltTest();
    $display("Done: %0d checks, %0d errors", checkCount, errorCount);
    if (errorCount == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

  initial begin
    while (cycleCount < cycleLimit) begin
      @(posedge clk);
      cycleCount++;
    end
    $display("Timeout: the tests did not finish within %0d cycles", cycleLimit);
    $display("Done: %0d checks, %0d errors", checkCount, errorCount);
    $display("ERRORS FOUND");
    $finish;
  end

endmodule

// ==== files.f ====
design/cpuPkg.sv
design/syncRam.sv
design/regFile.sv
design/controlUnit.sv
design/alu.sv
design/forwardingUnit.sv
design/hazardUnit.sv
design/pipeCpu.sv
test/pipeCpuTb.sv
